// File: logic/hpdmc_pkg.sv
// HPDMC command-side package
// Request, command and tag types shared by the queue, the FSM and the top level,
// plus the SDRAM spacing constants used by the data control and the bank timers
package hpdmc_pkg;

	localparam int HPDMC_NBANKS = 4; // Banks per SDRAM device

	typedef logic [1:0] hpdmc_bank_t; // Bank number
	typedef logic [12:0] hpdmc_row_t; // Row address
	typedef logic [3:0] hpdmc_tag_t; // Host identifier, returned with ack

	// Host request as stored in the request queue
	typedef struct packed {
		logic write; // High for a write, low for a read
		hpdmc_bank_t bank;
		hpdmc_row_t row;
		hpdmc_tag_t tag;
	} hpdmc_req_t;

	// SDRAM command kinds shown on the command port
	typedef enum logic [2:0] {
		CMD_NOP = 3'd0,
		CMD_PRECHARGE = 3'd1,
		CMD_ACTIVATE = 3'd2,
		CMD_READ = 3'd3,
		CMD_WRITE = 3'd4
	} hpdmc_cmd_e;

	typedef struct packed {
		hpdmc_cmd_e kind;
		hpdmc_bank_t bank; // Only meaningful when kind is not a nop
		hpdmc_row_t row; // Used by activate, carried along for the others
	} hpdmc_cmd_t;

	// Spacing loads for the read and write safety counters
	localparam logic [2:0] HPDMC_RD_TO_RD = 3'd4; // Burst of 4 transfers
	localparam logic [2:0] HPDMC_WR_TO_RD = 3'd5; // Burst plus one cycle of tWTR
	localparam logic [2:0] HPDMC_WR_TO_WR = 3'd3;
	localparam logic [2:0] HPDMC_RD_TO_WR = 3'd5; // One more when CAS latency is 3

	// Loads for the bank timers that guard precharge
	localparam logic [3:0] HPDMC_RD_TO_PRE = 4'd4;
	localparam logic [3:0] HPDMC_WR_TO_PRE = 4'd5; // Write recovery is added on top

	// Cycles the data bus stays turned around after a write
	localparam logic [1:0] HPDMC_WDIR_HOLD = 2'd3;

endpackage

// File: logic/hpdmc_fifo.sv
// Synchronous queue with a configurable payload type
// The head entry is visible on dout while the queue is not empty,
// so the consumer can look at it before it pops
`timescale 1ns/10ps

module hpdmc_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic sys_clk,
	input logic sdram_rst,
	input logic push,
	input payload_t din,
	input logic pop,
	output payload_t dout,
	output logic empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width
	localparam int CW = $clog2(DEPTH + 1); // Count must reach DEPTH

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_pop;

	assign do_pop = pop & ~empty; // A pop on an empty queue is ignored
	assign empty = (count == '0);
	assign dout = mem[rd_ptr]; // Head shown without waiting for a pop

	// Storage has no reset, only the pointers and the count are control state
	always_ff @(posedge sys_clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap at DEPTH
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // Both or neither leave the occupancy alone
			endcase
		end
	end

endmodule

// File: logic/hpdmc_banktimer.sv
// Bank precharge timer
// Counts down after a read or write to one bank and keeps precharge_safe low
// until the access has finished with the open row
`timescale 1ns/10ps

module hpdmc_banktimer
	import hpdmc_pkg::*;
(
	input logic sys_clk,
	input logic sdram_rst,
	input logic tim_cas, // Part of the bank timer interface, not needed by the count
	input logic [1:0] tim_wr, // Extra write recovery cycles
	input logic read,
	input logic write,
	output logic precharge_safe
);

	logic [3:0] counter; // Large enough for 5 plus the largest tim_wr

	// A read needs the burst to leave the row, a write also needs tWR
	// after its last data beat before the row may be closed
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			counter <= 4'd0;
			precharge_safe <= 1'b1; // All banks idle after reset
		end else begin
			if (read) begin
				counter <= HPDMC_RD_TO_PRE;
				precharge_safe <= 1'b0;
			end else if (write) begin
				counter <= HPDMC_WR_TO_PRE + {2'b00, tim_wr};
				precharge_safe <= 1'b0;
			end else begin
				if (counter == 4'd1)
					precharge_safe <= 1'b1; // Last cycle of the wait
				if (~precharge_safe)
					counter <= counter - 4'd1;
			end
		end
	end

endmodule

// File: logic/hpdmc_datactl.sv
// Data control for the HPDMC command side
// Guards read and write spacing, delays accesses into the ack pulse,
// drives the data-bus direction and holds one precharge timer per bank
`timescale 1ns/10ps

module hpdmc_datactl
	import hpdmc_pkg::*;
(
	input logic sys_clk,
	input logic sdram_rst,
	input logic read,
	input logic write,
	input logic [HPDMC_NBANKS-1:0] concerned_bank, // One-hot bank of the access
	output logic read_safe,
	output logic write_safe,
	output logic [HPDMC_NBANKS-1:0] precharge_safe,
	output logic ack,
	output logic direction, // Low while the controller drives the data bus
	input logic tim_cas,
	input logic [1:0] tim_wr
);

	logic [2:0] read_safe_counter;
	logic [2:0] write_safe_counter;
	logic [3:0] ack_read; // Read delay line, bit 0 is the oldest stage
	logic ack0;
	logic [1:0] counter_writedirection;
	logic direction0;

	// Read spacing after either kind of access
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			read_safe_counter <= 3'd0;
			read_safe <= 1'b1;
		end else if (read) begin
			read_safe_counter <= HPDMC_RD_TO_RD;
			read_safe <= 1'b0;
		end else if (write) begin
			read_safe_counter <= HPDMC_WR_TO_RD; // Write data must finish before tWTR
			read_safe <= 1'b0;
		end else begin
			if (read_safe_counter == 3'd1)
				read_safe <= 1'b1;
			if (~read_safe)
				read_safe_counter <= read_safe_counter - 3'd1;
		end
	end

	// Write spacing, a read needs its CAS latency to clear the bus first
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			write_safe_counter <= 3'd0;
			write_safe <= 1'b1;
		end else if (read) begin
			write_safe_counter <= HPDMC_RD_TO_WR + {2'b00, tim_cas};
			write_safe <= 1'b0;
		end else if (write) begin
			write_safe_counter <= HPDMC_WR_TO_WR;
			write_safe <= 1'b0;
		end else begin
			if (write_safe_counter == 3'd1)
				write_safe <= 1'b1;
			if (~write_safe)
				write_safe_counter <= write_safe_counter - 3'd1;
		end
	end

	// Reads reach ack after CL+3 cycles, writes after two
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			ack_read <= 4'd0;
			ack0 <= 1'b0;
			ack <= 1'b0;
		end else begin
			if (tim_cas)
				ack_read <= {read, ack_read[3:1]}; // Four stages for CL 3
			else
				ack_read <= {1'b0, read, ack_read[2:1]}; // Three stages for CL 2
			ack0 <= ack_read[0] | write;
			ack <= ack0;
		end
	end

	// Bus stays turned toward the SDRAM for the write burst
	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			counter_writedirection <= 2'd0;
		else if (write)
			counter_writedirection <= HPDMC_WDIR_HOLD;
		else if (|counter_writedirection)
			counter_writedirection <= counter_writedirection - 2'd1;
	end

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			direction0 <= 1'b1;
			direction <= 1'b1; // Controller does not drive the bus after reset
		end else begin
			direction0 <= ~(write | (|counter_writedirection));
			direction <= direction0; // Second stage lines up with the write data
		end
	end

	// One timer per bank, each sees only the accesses to its own bank
	for (genvar b = 0; b < HPDMC_NBANKS; b++) begin : g_banktimer
		hpdmc_banktimer u_banktimer (
			.sys_clk(sys_clk),
			.sdram_rst(sdram_rst),
			.tim_cas(tim_cas),
			.tim_wr(tim_wr),
			.read(read & concerned_bank[b]),
			.write(write & concerned_bank[b]),
			.precharge_safe(precharge_safe[b])
		);
	end

endmodule

// File: logic/hpdmc_mgmt.sv
// Bank management FSM
// Tracks the open row of every bank and turns the request at the queue head
// into precharge, activate and read or write commands
// Commands and the access strobes are combinational in the cycle they issue
`timescale 1ns/10ps

module hpdmc_mgmt
	import hpdmc_pkg::*;
#(
	parameter int TRCD = 2, // Activate to access, in cycles
	parameter int TRP = 2 // Precharge to activate, in cycles
) (
	input logic sys_clk,
	input logic sdram_rst,
	input hpdmc_req_t req_head,
	input logic req_empty,
	output logic req_pop,
	output logic read,
	output logic write,
	output logic [HPDMC_NBANKS-1:0] concerned_bank,
	input logic read_safe,
	input logic write_safe,
	input logic [HPDMC_NBANKS-1:0] precharge_safe,
	output hpdmc_cmd_t cmd,
	output logic tag_push
);

	localparam int TMAX = (TRP > TRCD) ? TRP : TRCD;
	localparam int CW = (TMAX > 1) ? $clog2(TMAX) : 1; // Holds TMAX-1

	typedef enum logic [1:0] {
		S_IDLE,
		S_PRE_WAIT,
		S_ACT_WAIT,
		S_ACCESS
	} state_e;

	state_e state;
	state_e state_next;
	logic [CW-1:0] wait_cnt; // Shared by the TRP and TRCD waits
	logic [HPDMC_NBANKS-1:0] bank_open;
	hpdmc_row_t open_row [HPDMC_NBANKS];
	logic row_hit;
	logic access_ok;
	logic issue_pre;
	logic issue_act;
	logic issue_acc;

	assign row_hit = bank_open[req_head.bank] && (open_row[req_head.bank] == req_head.row);
	assign access_ok = req_head.write ? write_safe : read_safe; // Spacing from datactl
	assign concerned_bank = {{(HPDMC_NBANKS - 1){1'b0}}, 1'b1} << req_head.bank;

	always_comb begin
		issue_pre = 1'b0;
		issue_act = 1'b0;
		issue_acc = 1'b0;
		state_next = state;
		case (state)
			S_IDLE: begin
				if (!req_empty) begin
					if (row_hit) begin
						if (access_ok)
							issue_acc = 1'b1; // Hit with the bus free goes out at once
						else
							state_next = S_ACCESS;
					end else if (!bank_open[req_head.bank]) begin
						issue_act = 1'b1; // Closed bank needs no precharge
						state_next = S_ACT_WAIT;
					end else if (precharge_safe[req_head.bank]) begin
						issue_pre = 1'b1; // Wrong row open, close it first
						state_next = S_PRE_WAIT;
					end
				end
			end
			S_PRE_WAIT: begin
				if (wait_cnt == '0) begin
					issue_act = 1'b1;
					state_next = S_ACT_WAIT;
				end
			end
			S_ACT_WAIT: begin
				if (wait_cnt == '0)
					state_next = S_ACCESS;
			end
			S_ACCESS: begin
				if (access_ok) begin
					issue_acc = 1'b1;
					state_next = S_IDLE;
				end
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			state <= S_IDLE;
			wait_cnt <= '0;
			bank_open <= '0; // All rows closed after reset
		end else begin
			state <= state_next;
			if (issue_pre) begin
				wait_cnt <= CW'(TRP - 1);
				bank_open[req_head.bank] <= 1'b0;
			end else if (issue_act) begin
				wait_cnt <= CW'(TRCD - 1);
				bank_open[req_head.bank] <= 1'b1;
			end else if (wait_cnt != '0) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	// Row numbers are only looked at while the open flag is set
	always_ff @(posedge sys_clk) begin
		if (issue_act)
			open_row[req_head.bank] <= req_head.row;
	end

	assign req_pop = issue_acc; // The request leaves the queue with its access
	assign tag_push = issue_acc;
	assign read = issue_acc & ~req_head.write;
	assign write = issue_acc & req_head.write;

	always_comb begin
		cmd.bank = req_head.bank;
		cmd.row = req_head.row;
		if (issue_pre)
			cmd.kind = CMD_PRECHARGE;
		else if (issue_act)
			cmd.kind = CMD_ACTIVATE;
		else if (issue_acc)
			cmd.kind = req_head.write ? CMD_WRITE : CMD_READ;
		else
			cmd.kind = CMD_NOP; // Idle or waiting on a timer
	end

endmodule

// File: logic/hpdmc_ctl_top.sv
// HPDMC command-side top level
// Request queue with credit return, bank management FSM, data control,
// and a tag queue that hands each access's tag back with its ack
`timescale 1ns/10ps

module hpdmc_ctl_top
	import hpdmc_pkg::*;
#(
	parameter int REQ_DEPTH = 4, // Also the host's starting credit count
	parameter int TAG_DEPTH = 8,
	parameter int TRCD = 2,
	parameter int TRP = 2
) (
	input logic sys_clk,
	input logic sdram_rst,
	input logic req_valid,
	input hpdmc_req_t req,
	input logic tim_cas,
	input logic [1:0] tim_wr,
	output logic credit_return,
	output hpdmc_cmd_t cmd,
	output logic ack,
	output hpdmc_tag_t ack_tag,
	output logic direction
);

	hpdmc_req_t req_head;
	logic req_empty;
	logic req_pop;
	logic read;
	logic write;
	logic [HPDMC_NBANKS-1:0] concerned_bank;
	logic read_safe;
	logic write_safe;
	logic [HPDMC_NBANKS-1:0] precharge_safe;
	logic tag_push;

	assign credit_return = req_pop; // Each pop frees one slot for the host

	hpdmc_fifo #(.payload_t(hpdmc_req_t), .DEPTH(REQ_DEPTH)) u_req_fifo (
		.sys_clk(sys_clk), .sdram_rst(sdram_rst),
		.push(req_valid), .din(req),
		.pop(req_pop), .dout(req_head), .empty(req_empty)
	);

	hpdmc_mgmt #(.TRCD(TRCD), .TRP(TRP)) u_mgmt (
		.sys_clk(sys_clk), .sdram_rst(sdram_rst),
		.req_head(req_head), .req_empty(req_empty), .req_pop(req_pop),
		.read(read), .write(write), .concerned_bank(concerned_bank),
		.read_safe(read_safe), .write_safe(write_safe),
		.precharge_safe(precharge_safe), .cmd(cmd), .tag_push(tag_push)
	);

	hpdmc_datactl u_datactl (
		.sys_clk(sys_clk), .sdram_rst(sdram_rst),
		.read(read), .write(write), .concerned_bank(concerned_bank),
		.read_safe(read_safe), .write_safe(write_safe),
		.precharge_safe(precharge_safe), .ack(ack), .direction(direction),
		.tim_cas(tim_cas), .tim_wr(tim_wr)
	);

	// Acks never reorder, so the head tag always belongs to the acked access
	hpdmc_fifo #(.payload_t(hpdmc_tag_t), .DEPTH(TAG_DEPTH)) u_tag_fifo (
		.sys_clk(sys_clk), .sdram_rst(sdram_rst),
		.push(tag_push), .din(req_head.tag),
		.pop(ack), .dout(ack_tag), .empty()
	);

endmodule

// File: sim/tb_hpdmc_model.svh
// Reference model of the SDRAM command side
// Open row per bank, stamps of the last command of each kind and the acks still due
`ifndef TB_HPDMC_MODEL_SVH
`define TB_HPDMC_MODEL_SVH

typedef struct packed {
	logic [31:0] due; // Cycle the ack must appear in
	hpdmc_tag_t tag;
} exp_ack_t;

hpdmc_req_t pend_q[$]; // Accepted by the DUT, access not yet issued
exp_ack_t ack_q[$];
logic m_open [HPDMC_NBANKS];
hpdmc_row_t m_row [HPDMC_NBANKS];
int last_rd;
int last_wr;
int last_rd_bank [HPDMC_NBANKS];
int last_wr_bank [HPDMC_NBANKS];
int last_act [HPDMC_NBANKS];
int last_pre [HPDMC_NBANKS];
logic [7:0] wr_hist; // Bit k set when a write went out k cycles ago

function automatic void model_reset();
	last_rd = -100; // Far in the past so the first commands are never too close
	last_wr = -100;
	wr_hist = '0;
	for (int b = 0; b < HPDMC_NBANKS; b++) begin
		m_open[b] = 1'b0; // All banks closed after reset
		m_row[b] = '0;
		last_rd_bank[b] = -100;
		last_wr_bank[b] = -100;
		last_act[b] = -100;
		last_pre[b] = -100;
	end
endfunction

// Writes ack after two cycles, reads after CAS latency plus the burst
function automatic int ack_delay(logic is_write);
	if (is_write)
		return 2;
	return tim_cas ? 6 : 5;
endfunction

function automatic void note_access(logic is_write, hpdmc_bank_t b, int c);
	if (is_write) begin
		last_wr = c;
		last_wr_bank[b] = c;
	end else begin
		last_rd = c;
		last_rd_bank[b] = c;
	end
endfunction

// Names the broken spacing rule, empty when the command may go out now
function automatic string spacing_error(hpdmc_cmd_e kind, hpdmc_bank_t b, int c);
	case (kind)
		CMD_READ: begin
			if (c - last_rd < 4)
				return "read within 4 cycles of a read";
			if (c - last_wr < 5)
				return "read within 5 cycles of a write";
		end
		CMD_WRITE: begin
			if (c - last_wr < 3)
				return "write within 3 cycles of a write";
			if (c - last_rd < (tim_cas ? 6 : 5))
				return "write too soon after a read";
		end
		CMD_PRECHARGE: begin
			if (c - last_rd_bank[b] < 4)
				return "precharge within 4 cycles of a read to its bank";
			if (c - last_wr_bank[b] < 5 + int'(tim_wr))
				return "precharge before write recovery of its bank ended";
		end
		CMD_ACTIVATE: begin
			if (c - last_pre[b] < TRP)
				return "activate within TRP of the precharge of its bank";
		end
		default: ;
	endcase
	if ((kind == CMD_READ || kind == CMD_WRITE) && c - last_act[b] < TRCD)
		return "access within TRCD of the activate of its bank";
	return "";
endfunction

`endif

// File: sim/tb_hpdmc.sv
// Testbench for the HPDMC command side
// Random host requests in two timing phases, with every output checked each cycle
// against a reference model of bank state, spacing rules and ack timing
`timescale 1ns/10ps

module tb_hpdmc
	import hpdmc_pkg::*;
#(
	parameter int NUM_REQS = 400,
	parameter int REQ_DEPTH = 4,
	parameter int TRCD = 2,
	parameter int TRP = 2
);

	localparam int CLK_PERIOD = 10;
	localparam int SEED = 32'h2b88414d;

	logic sys_clk = 1'b0;
	logic sdram_rst;
	logic req_valid;
	hpdmc_req_t req;
	logic tim_cas;
	logic [1:0] tim_wr;
	logic credit_return;
	hpdmc_cmd_t cmd;
	logic ack;
	hpdmc_tag_t ack_tag;
	logic direction;

	int cyc; // Cycles since reset release as counted at the falling edge
	int sent; // Requests pushed by the host
	int returned; // credit_return pulses seen
	logic first_req_seen;
	int err_credit;
	int err_cmd;
	int err_ack;
	int err_dir;
	int err_reset;

	`include "tb_hpdmc_model.svh"

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	hpdmc_ctl_top #(.REQ_DEPTH(REQ_DEPTH), .TAG_DEPTH(8), .TRCD(TRCD), .TRP(TRP)) u_dut (
		.sys_clk(sys_clk), .sdram_rst(sdram_rst),
		.req_valid(req_valid), .req(req), .tim_cas(tim_cas), .tim_wr(tim_wr),
		.credit_return(credit_return), .cmd(cmd), .ack(ack), .ack_tag(ack_tag),
		.direction(direction)
	);

	function automatic int error_total();
		return err_credit + err_cmd + err_ack + err_dir + err_reset;
	endfunction

	function automatic void print_counts();
		$display("errors %0d: credit %0d, command %0d, ack %0d, direction %0d, reset %0d",
			error_total(), err_credit, err_cmd, err_ack, err_dir, err_reset);
	endfunction

	task automatic check_ack();
		if (ack_q.size() > 0 && int'(ack_q[0].due) == cyc) begin
			if (!ack) begin
				err_ack++;
				$display("ack missing at cycle %0d for tag %0h", cyc, ack_q[0].tag);
			end else if (ack_tag != ack_q[0].tag) begin
				err_ack++;
				$display("mismatch ack_tag at cycle %0d: expected %0h actual %0h",
					cyc, ack_q[0].tag, ack_tag);
			end
			ack_q.delete(0);
		end else if (ack) begin
			err_ack++; // Early, late or extra pulse
			$display("ack at cycle %0d with no access due", cyc);
		end
	endtask

	// The queue head is the only request the FSM may be working on
	task automatic check_command();
		hpdmc_cmd_e kind;
		hpdmc_bank_t b;
		hpdmc_req_t head;
		exp_ack_t due_ack;
		string why;
		logic is_access;
		kind = cmd.kind;
		b = cmd.bank;
		is_access = (kind == CMD_READ) || (kind == CMD_WRITE);
		if (pend_q.size() == 0) begin
			err_cmd++;
			$display("%s issued at cycle %0d with no request pending", kind.name(), cyc);
			return;
		end
		head = pend_q[0];
		why = spacing_error(kind, b, cyc);
		if (why != "") begin
			err_cmd++;
			$display("%s at cycle %0d", why, cyc);
		end
		if (b != head.bank) begin
			err_cmd++;
			$display("mismatch cmd_bank at cycle %0d: expected %0d actual %0d", cyc, head.bank, b);
		end
		if (credit_return != is_access) begin
			err_credit++;
			$display("mismatch credit_return at cycle %0d: expected %0b actual %0b",
				cyc, is_access, credit_return);
		end
		case (kind)
			CMD_PRECHARGE: begin
				if (!m_open[b] || m_row[b] == head.row) begin
					err_cmd++; // Closed bank, or a row hit that needed no precharge
					$display("needless precharge of bank %0d at cycle %0d", b, cyc);
				end
				m_open[b] = 1'b0;
				last_pre[b] = cyc;
			end
			CMD_ACTIVATE: begin
				if (m_open[b]) begin
					err_cmd++;
					$display("activate of open bank %0d at cycle %0d", b, cyc);
				end
				if (cmd.row != head.row) begin
					err_cmd++;
					$display("mismatch activate_row: expected %0h actual %0h", head.row, cmd.row);
				end
				m_open[b] = 1'b1;
				m_row[b] = cmd.row;
				last_act[b] = cyc;
			end
			CMD_READ, CMD_WRITE: begin
				if (!m_open[b] || m_row[b] != head.row) begin
					err_cmd++;
					$display("access at cycle %0d without row %0h open in bank %0d",
						cyc, head.row, b);
				end
				if ((kind == CMD_WRITE) != head.write) begin
					err_cmd++;
					$display("mismatch access_kind: expected write=%0b actual %s",
						head.write, kind.name());
				end
				note_access(kind == CMD_WRITE, b, cyc);
				due_ack.due = cyc + ack_delay(kind == CMD_WRITE);
				due_ack.tag = head.tag;
				ack_q.push_back(due_ack);
				head = pend_q.pop_front();
			end
			default: begin
				err_cmd++;
				$display("unknown command code %0d at cycle %0d", cmd.kind, cyc);
			end
		endcase
	endtask

	// Checks everything the DUT shows in one cycle where it is stable
	task automatic check_cycle();
		int credits;
		logic exp_dir;
		cyc++;
		wr_hist = {wr_hist[6:0], cmd.kind == CMD_WRITE};
		if (credit_return)
			returned++;
		credits = REQ_DEPTH - sent + returned;
		if (credits > REQ_DEPTH) begin
			err_credit++; // More credits came back than the host spent
			$display("host credit count %0d above its starting value at cycle %0d", credits, cyc);
		end
		if (!first_req_seen && (cmd.kind != CMD_NOP || ack || credit_return || !direction)) begin
			err_reset++;
			$display("outputs left their reset values before the first request, cycle %0d", cyc);
		end
		check_ack();
		if (cmd.kind != CMD_NOP) begin
			check_command();
		end else if (credit_return) begin
			err_credit++;
			$display("credit_return without an access at cycle %0d", cyc);
		end
		exp_dir = ~|wr_hist[5:2]; // Bus turned 2 to 5 cycles after each write
		if (direction != exp_dir) begin
			err_dir++;
			$display("mismatch direction at cycle %0d: expected %0b actual %0b",
				cyc, exp_dir, direction);
		end
	endtask

	always @(negedge sys_clk) begin
		if (sdram_rst == 1'b0)
			check_cycle();
	end

	// One phase of random requests under a fixed CAS latency and write recovery
	task automatic run_phase(input int n, input logic cas, input logic [1:0] wr);
		hpdmc_req_t r;
		int issued;
		issued = 0;
		@(posedge sys_clk);
		tim_cas <= cas;
		tim_wr <= wr;
		while (issued < n) begin
			@(posedge sys_clk);
			if (sent - returned < REQ_DEPTH && $urandom_range(3, 0) != 0) begin
				r.write = 1'($urandom_range(1, 0));
				r.bank = hpdmc_bank_t'($urandom_range(HPDMC_NBANKS - 1, 0));
				r.row = hpdmc_row_t'($urandom_range(2, 0) * 32'h155); // Three rows give hits and misses
				r.tag = hpdmc_tag_t'($urandom);
				req <= r;
				req_valid <= 1'b1;
				pend_q.push_back(r);
				sent++;
				issued++;
				first_req_seen = 1'b1;
			end else begin
				req_valid <= 1'b0;
			end
		end
		@(posedge sys_clk);
		req_valid <= 1'b0;
		while (pend_q.size() != 0 || ack_q.size() != 0)
			@(posedge sys_clk);
		repeat (12) @(posedge sys_clk); // Timers settle before the timing inputs change
	endtask

	initial begin
		sdram_rst <= 1'b1;
		req_valid <= 1'b0;
		req <= '0;
		tim_cas <= 1'b0;
		tim_wr <= 2'd0;
		cyc = 0;
		sent = 0;
		returned = 0;
		first_req_seen = 1'b0;
		err_credit = 0;
		err_cmd = 0;
		err_ack = 0;
		err_dir = 0;
		err_reset = 0;
		void'($urandom(SEED));
		model_reset();
		repeat (5) @(posedge sys_clk);
		sdram_rst <= 1'b0;
		run_phase(NUM_REQS / 2, 1'b0, 2'd1);
		run_phase(NUM_REQS - NUM_REQS / 2, 1'b1, 2'd3);
		if (sent != returned || returned != NUM_REQS) begin
			err_credit++;
			$display("credits not all back: %0d sent, %0d returned of %0d",
				sent, returned, NUM_REQS);
		end
		print_counts();
		if (error_total() == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Watchdog allows a generous 30 cycles per request
	initial begin
		#(NUM_REQS * 30 * CLK_PERIOD);
		$display("timeout at cycle %0d with %0d of %0d credits returned",
			cyc, returned, NUM_REQS);
		print_counts();
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: all.f
+incdir+sim
logic/hpdmc_pkg.sv
logic/hpdmc_fifo.sv
logic/hpdmc_banktimer.sv
logic/hpdmc_datactl.sv
logic/hpdmc_mgmt.sv
logic/hpdmc_ctl_top.sv
sim/tb_hpdmc.sv

// File: Makefile
# Verilator build and run of the HPDMC command-side testbench

VERILATOR ?= verilator
TOP ?= tb_hpdmc
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) sim/tb_hpdmc_model.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
